//--- fetch_frontend.f
+incdir+.
fetch_pkg.sv
branch_target_buffer.sv
direction_predictor.sv
fetch_sequencer.sv
fetch_frontend.sv
fetch_frontend_tb.sv

//--- fetch_frontend_tb.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_frontend_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  localparam int RESET_CYCLES  = 8;
  localparam int RANDOM_CYCLES = 400;
  localparam int WAIT_LIMIT    = 40;
  // worst case length of all tests in clock cycles
  localparam int TEST_CYCLES   = RESET_CYCLES + 20 + WAIT_LIMIT + 10 + WAIT_LIMIT + RANDOM_CYCLES;
  localparam ip_t BRANCH_IP    = 32'h0000_1200;
  localparam ip_t BRANCH_TGT   = 32'h0000_5000;

  logic clk;
  logic rst;
  logic retire_valid;
  ip_t  retire_ip;
  ghr_t retire_ghr;
  logic retire_taken;
  ip_t  retire_target;
  logic retire_mispredict;
  logic fetch_valid;
  ip_t  fetch_ip;
  ghr_t fetch_ghr;
  logic fetch_taken;

  // reference model state
  logic        m_valid;
  ip_t         m_ip;
  ghr_t        m_ghr;
  logic        btb_v   [64];
  logic [21:0] btb_tag [64];
  ip_t         btb_tgt [64];
  logic [1:0]  pht_m   [3][1024];
  ghr_t        ghr_log [$]; // recent fetch histories that feed retire_ghr

  int error_count = 0;
  int check_count = 0;
  int tests_run   = 0;
  int seed_value;

  fetch_frontend i_fetch_frontend (
    .clk              (clk),
    .rst              (rst),
    .retire_valid     (retire_valid),
    .retire_ip        (retire_ip),
    .retire_ghr       (retire_ghr),
    .retire_taken     (retire_taken),
    .retire_target    (retire_target),
    .retire_mispredict(retire_mispredict),
    .fetch_valid      (fetch_valid),
    .fetch_ip         (fetch_ip),
    .fetch_ghr        (fetch_ghr),
    .fetch_taken      (fetch_taken)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic pht_index_t table_index(input ip_t ip, input ghr_t ghr, input int t);
    pht_index_t base;
    base = ip[13:4];
    case (t)
      0: return base ^ {8'b0, ghr[1:0]};
      1: return base ^ {4'b0, ghr[5:0]};
      default: return base ^ ghr[9:0] ^ {6'b0, ghr[13:10]}; // 14 bits folded to 10
    endcase
  endfunction

  function automatic logic model_hit(input ip_t ip);
    return btb_v[ip[9:4]] && (btb_tag[ip[9:4]] == ip[31:10]);
  endfunction

  function automatic logic model_predicts(input ip_t ip, input ghr_t ghr);
    int votes;
    votes = 0;
    for (int t = 0; t < 3; t++) begin
      if (pht_m[t][table_index(ip, ghr, t)] >= 2'd2) begin
        votes++;
      end
    end
    return votes >= 2;
  endfunction

  // next fetch state from model tables and the retire inputs of this cycle
  function automatic void expected_next(input ip_t ip, input ghr_t ghr, output ip_t next_ip,
                                        output ghr_t next_ghr, output logic taken);
    logic hit;
    hit   = model_hit(ip);
    taken = hit && model_predicts(ip, ghr);
    if (retire_valid && retire_mispredict) begin
      next_ip  = retire_taken ? retire_target : retire_ip + `FETCH_BLOCK_BYTES;
      next_ghr = (retire_ghr << 1) | ghr_t'(retire_taken);
    end else if (taken) begin
      next_ip  = btb_tgt[ip[9:4]];
      next_ghr = (ghr << 1) | 14'd1;
    end else begin
      next_ip  = ip + `FETCH_BLOCK_BYTES;
      next_ghr = hit ? ghr << 1 : ghr; // no hit means no branch seen
    end
  endfunction

  function automatic void clear_model();
    m_valid = 1'b0;
    m_ip    = `FETCH_RESET_IP;
    m_ghr   = '0;
    ghr_log.delete();
    for (int i = 0; i < 64; i++) begin
      btb_v[i] = 1'b0;
    end
    for (int t = 0; t < 3; t++) begin
      for (int i = 0; i < 1024; i++) begin
        pht_m[t][i] = 2'b01; // weak not-taken
      end
    end
  endfunction

  // compare at the falling edge and then step the model
  always @(negedge clk) begin : compare
    ip_t        nip;
    ghr_t       nghr;
    logic       exp_taken;
    pht_index_t idx;
    if (rst) begin
      clear_model();
      check_value("fetch_valid", fetch_valid, 1'b0);
    end else begin
      check_value("fetch_valid", fetch_valid, m_valid);
      if (m_valid) begin
        expected_next(m_ip, m_ghr, nip, nghr, exp_taken);
        check_value("fetch_ip", fetch_ip, m_ip);
        check_value("fetch_ghr", fetch_ghr, m_ghr);
        check_value("fetch_taken", fetch_taken, exp_taken);
        ghr_log.push_back(m_ghr);
        if (ghr_log.size() > 16) begin
          ghr_log.delete(0);
        end
        m_ip  = nip;
        m_ghr = nghr;
      end
      m_valid = 1'b1;
      if (retire_valid) begin
        for (int t = 0; t < 3; t++) begin
          idx = table_index(retire_ip, retire_ghr, t);
          if (retire_taken && pht_m[t][idx] != 2'd3) begin
            pht_m[t][idx] = pht_m[t][idx] + 2'd1;
          end else if (!retire_taken && pht_m[t][idx] != 2'd0) begin
            pht_m[t][idx] = pht_m[t][idx] - 2'd1;
          end
        end
        if (retire_taken) begin
          btb_v[retire_ip[9:4]]   = 1'b1;
          btb_tag[retire_ip[9:4]] = retire_ip[31:10];
          btb_tgt[retire_ip[9:4]] = retire_target;
        end
      end
    end
  end

  task automatic drive_retire(input ip_t ip, input ghr_t ghr, input logic taken,
                              input ip_t target, input logic mispredict);
    @(posedge clk);
    retire_valid      <= 1'b1;
    retire_ip         <= ip;
    retire_ghr        <= ghr;
    retire_taken      <= taken;
    retire_target     <= target;
    retire_mispredict <= mispredict;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    retire_valid      <= 1'b0;
    retire_mispredict <= 1'b0;
  endtask

  task automatic wait_for_ip(input ip_t ip, output logic found);
    found = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
      @(negedge clk);
      found = (fetch_ip == ip);
    end
    if (!found) begin
      error_count++;
      $display("fetch did not reach address %h within %0d cycles", ip, WAIT_LIMIT);
    end
  endtask

  function automatic ip_t pool_ip(input int k);
    case (k)
      0: return 32'h0000_1200;
      1: return 32'h0000_5200; // same btb slot and pht base as 1200
      2: return 32'h0000_1240;
      3: return 32'h0000_9240; // aliases 1240
      4: return 32'h0000_1080;
      5: return 32'h0000_1400;
      6: return 32'h0000_13f0;
      default: return 32'h0000_1a00;
    endcase
  endfunction

  task automatic reset_then_step();
    logic found;
    found = 1'b0;
    for (int n = 0; n < 4 && !found; n++) begin
      @(negedge clk);
      found = fetch_valid;
    end
    if (!found) begin
      error_count++;
      $display("fetch_valid never went high after reset");
    end
    check_value("fetch_ip", fetch_ip, `FETCH_RESET_IP);
    for (int k = 1; k <= 6; k++) begin
      @(negedge clk);
      check_value("fetch_ip", fetch_ip, `FETCH_RESET_IP + 16 * k);
      check_value("fetch_ghr", fetch_ghr, 32'd0);
      check_value("fetch_taken", fetch_taken, 1'b0);
    end
  endtask

  task automatic learn_taken_branch();
    logic found;
    drive_retire(BRANCH_IP, '0, 1'b1, BRANCH_TGT, 1'b0);
    drive_idle();
    wait_for_ip(BRANCH_IP, found);
    if (found) begin
      check_value("fetch_taken", fetch_taken, 1'b1);
      @(negedge clk);
      check_value("fetch_ip", fetch_ip, BRANCH_TGT);
      check_value("fetch_ghr", fetch_ghr, 32'h0001);
    end
  endtask

  task automatic restore_on_mispredict();
    drive_retire(32'h0000_3000, 14'h0155, 1'b1, 32'h0000_2000, 1'b1);
    drive_idle();
    @(negedge clk);
    check_value("fetch_ip", fetch_ip, 32'h0000_2000);
    check_value("fetch_ghr", fetch_ghr, 32'h02ab); // 155 shifted left with a one in
    drive_retire(32'h0000_3100, 14'h02a3, 1'b0, 32'h0000_7700, 1'b1);
    drive_idle();
    @(negedge clk);
    check_value("fetch_ip", fetch_ip, 32'h0000_3110);
    check_value("fetch_ghr", fetch_ghr, 32'h0546);
  endtask

  task automatic train_branch_down();
    logic found;
    drive_retire(BRANCH_IP, 14'h0006, 1'b1, BRANCH_TGT, 1'b0);
    drive_retire(BRANCH_IP, 14'h0006, 1'b0, BRANCH_TGT, 1'b0);
    drive_retire(BRANCH_IP, 14'h0006, 1'b0, BRANCH_TGT, 1'b0);
    // restore four blocks back so history becomes 6
    drive_retire(BRANCH_IP - 32'd80, 14'h0003, 1'b0, '0, 1'b1);
    drive_idle();
    wait_for_ip(BRANCH_IP, found);
    if (found) begin
      check_value("fetch_ghr", fetch_ghr, 32'h0006);
      check_value("fetch_taken", fetch_taken, 1'b0);
      @(negedge clk);
      check_value("fetch_ip", fetch_ip, BRANCH_IP + 32'd16);
      check_value("fetch_ghr", fetch_ghr, 32'h000c);
    end
  endtask

  task automatic mix_random_retires();
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      @(posedge clk);
      if ($urandom % 2 == 1) begin
        retire_valid      <= 1'b1;
        retire_ip         <= pool_ip($urandom % 8);
        retire_ghr        <= ghr_log[$urandom % ghr_log.size()];
        retire_taken      <= $urandom % 2;
        retire_target     <= 32'h0000_1000 + (($urandom % 128) * 16);
        retire_mispredict <= ($urandom % 4) == 0;
      end else begin
        retire_valid      <= 1'b0;
        retire_mispredict <= 1'b0;
      end
    end
    drive_idle();
  endtask

  task automatic report_test(input int num, input string name, input int start_errors);
    tests_run++;
    $display("test %0d %s: %s", num, name, (error_count == start_errors) ? "passed" : "failed");
  endtask

  initial begin : watchdog
    repeat (TEST_CYCLES + 100) @(posedge clk);
    $display("timeout, tests still running after %0d cycles", TEST_CYCLES + 100);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int start;
    rst               <= 1'b1;
    retire_valid      <= 1'b0;
    retire_ip         <= '0;
    retire_ghr        <= '0;
    retire_taken      <= 1'b0;
    retire_target     <= '0;
    retire_mispredict <= 1'b0;
    seed_value = $urandom(32'h2db8);
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    start = error_count;
    reset_then_step();
    report_test(1, "reset and sequential fetch", start);
    start = error_count;
    learn_taken_branch();
    report_test(2, "learning a taken branch", start);
    start = error_count;
    restore_on_mispredict();
    report_test(3, "mispredict restore", start);
    start = error_count;
    train_branch_down();
    report_test(4, "training back to not-taken", start);
    start = error_count;
    mix_random_retires();
    repeat (2) @(negedge clk);
    report_test(5, "random mix", start);

    $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_frontend.sv
`default_nettype none

module fetch_frontend (
  input  logic            clk,
  input  logic            rst,
  input  logic            retire_valid,
  input  fetch_pkg::ip_t  retire_ip,
  input  fetch_pkg::ghr_t retire_ghr,
  input  logic            retire_taken,
  input  fetch_pkg::ip_t  retire_target,
  input  logic            retire_mispredict,
  output logic            fetch_valid,
  output fetch_pkg::ip_t  fetch_ip,
  output fetch_pkg::ghr_t fetch_ghr,
  output logic            fetch_taken
);
  import fetch_pkg::*;

  logic btb_hit;
  ip_t  btb_target;
  logic pred_taken;

  // lookups run off the registered fetch address
  branch_target_buffer i_branch_target_buffer (
    .clk          (clk),
    .rst          (rst),
    .fetch_ip     (fetch_ip),
    .retire_valid (retire_valid),
    .retire_taken (retire_taken),
    .retire_ip    (retire_ip),
    .retire_target(retire_target),
    .btb_hit      (btb_hit),
    .btb_target   (btb_target)
  );

  direction_predictor i_direction_predictor (
    .clk         (clk),
    .rst         (rst),
    .fetch_ip    (fetch_ip),
    .fetch_ghr   (fetch_ghr),
    .retire_valid(retire_valid),
    .retire_ip   (retire_ip),
    .retire_ghr  (retire_ghr),
    .retire_taken(retire_taken),
    .pred_taken  (pred_taken)
  );

  fetch_sequencer i_fetch_sequencer (
    .clk              (clk),
    .rst              (rst),
    .btb_hit          (btb_hit),
    .btb_target       (btb_target),
    .pred_taken       (pred_taken),
    .retire_valid     (retire_valid),
    .retire_ip        (retire_ip),
    .retire_ghr       (retire_ghr),
    .retire_taken     (retire_taken),
    .retire_target    (retire_target),
    .retire_mispredict(retire_mispredict),
    .fetch_valid      (fetch_valid),
    .fetch_ip         (fetch_ip),
    .fetch_ghr        (fetch_ghr),
    .fetch_taken      (fetch_taken)
  );

endmodule

`default_nettype wire

//--- fetch_sequencer.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_sequencer (
  input  logic            clk,
  input  logic            rst,
  input  logic            btb_hit,
  input  fetch_pkg::ip_t  btb_target,
  input  logic            pred_taken,
  input  logic            retire_valid,
  input  fetch_pkg::ip_t  retire_ip,
  input  fetch_pkg::ghr_t retire_ghr,
  input  logic            retire_taken,
  input  fetch_pkg::ip_t  retire_target,
  input  logic            retire_mispredict,
  output logic            fetch_valid,
  output fetch_pkg::ip_t  fetch_ip,
  output fetch_pkg::ghr_t fetch_ghr,
  output logic            fetch_taken
);
  import fetch_pkg::*;

  localparam ip_t BLOCK_STEP = ip_t'(`FETCH_BLOCK_BYTES);

  next_kind_e next_kind;
  ip_t        next_ip;
  ghr_t       next_ghr;

  assign fetch_taken = btb_hit && pred_taken;

  // retire correction beats the current prediction
  always_comb begin
    if (retire_valid && retire_mispredict) begin
      next_kind = NEXT_RESTORE;
    end else if (fetch_taken) begin
      next_kind = NEXT_TAKEN;
    end else begin
      next_kind = NEXT_SEQ;
    end
  end

  always_comb begin
    next_ip  = fetch_ip + BLOCK_STEP;
    next_ghr = fetch_ghr;
    case (next_kind)
      NEXT_RESTORE: begin
        next_ip  = retire_taken ? retire_target : retire_ip + BLOCK_STEP;
        next_ghr = {retire_ghr[`FETCH_GHR_W-2:0], retire_taken};
      end
      NEXT_TAKEN: begin
        next_ip  = btb_target;
        next_ghr = {fetch_ghr[`FETCH_GHR_W-2:0], 1'b1};
      end
      default: begin
        // known branch predicted not taken still counts in history
        if (btb_hit) begin
          next_ghr = {fetch_ghr[`FETCH_GHR_W-2:0], 1'b0};
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_valid <= 1'b0;
      fetch_ip    <= ip_t'(`FETCH_RESET_IP);
      fetch_ghr   <= '0;
    end else if (!fetch_valid) begin
      fetch_valid <= 1'b1; // hold reset address for the first fetch
    end else begin
      fetch_ip  <= next_ip;
      fetch_ghr <= next_ghr;
    end
  end

endmodule

`default_nettype wire

//--- direction_predictor.sv
`default_nettype none

`include "fetch_macros.svh"

module direction_predictor (
  input  logic            clk,
  input  logic            rst,
  input  fetch_pkg::ip_t  fetch_ip,
  input  fetch_pkg::ghr_t fetch_ghr,
  input  logic            retire_valid,
  input  fetch_pkg::ip_t  retire_ip,
  input  fetch_pkg::ghr_t retire_ghr,
  input  logic            retire_taken,
  output logic            pred_taken
);
  import fetch_pkg::*;

  localparam int unsigned ENTRIES = 2 ** `FETCH_PHT_IDX_W;
  localparam int unsigned TABLES  = 3;

  // table 0 short history, 1 medium, 2 full history folded
  function automatic pht_index_t pht_hash(input ip_t ip, input ghr_t ghr, input int sel);
    pht_index_t base;
    pht_index_t hist;
    base = ip[`FETCH_PHT_IDX_W+FETCH_OFS_W-1:FETCH_OFS_W];
    case (sel)
      0: hist = pht_index_t'(ghr[`FETCH_HIST_SHORT-1:0]);
      1: hist = pht_index_t'(ghr[`FETCH_HIST_MID-1:0]);
      default: begin
        hist = ghr[`FETCH_PHT_IDX_W-1:0]
             ^ pht_index_t'(ghr[`FETCH_GHR_W-1:`FETCH_PHT_IDX_W]);
      end
    endcase
    return base ^ hist;
  endfunction

  // one step toward the outcome, saturating at both ends
  function automatic counter_e sat_step(input counter_e cnt, input logic taken);
    counter_e res;
    case (cnt)
      CNT_STRONG_NT: res = taken ? CNT_WEAK_NT : CNT_STRONG_NT;
      CNT_WEAK_NT:   res = taken ? CNT_WEAK_T : CNT_STRONG_NT;
      CNT_WEAK_T:    res = taken ? CNT_STRONG_T : CNT_WEAK_NT;
      default:       res = taken ? CNT_STRONG_T : CNT_WEAK_T;
    endcase
    return res;
  endfunction

  logic [TABLES-1:0] vote;

  for (genvar t = 0; t < TABLES; t++) begin : g_table
    counter_e   pht [ENTRIES];
    pht_index_t rd_idx;
    pht_index_t wr_idx;
    counter_e   rd_cnt;

    assign rd_idx  = pht_hash(fetch_ip, fetch_ghr, t);
    assign wr_idx  = pht_hash(retire_ip, retire_ghr, t);
    assign rd_cnt  = pht[rd_idx];
    assign vote[t] = rd_cnt[1]; // weak or strong taken

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < ENTRIES; i++) begin
          pht[i] <= CNT_WEAK_NT;
        end
      end else if (retire_valid) begin
        pht[wr_idx] <= sat_step(pht[wr_idx], retire_taken);
      end
    end
  end

  // two of three
  assign pred_taken = (vote[0] && vote[1]) || (vote[0] && vote[2]) || (vote[1] && vote[2]);

endmodule

`default_nettype wire

//--- branch_target_buffer.sv
`default_nettype none

`include "fetch_macros.svh"

module branch_target_buffer (
  input  logic           clk,
  input  logic           rst,
  input  fetch_pkg::ip_t fetch_ip,
  input  logic           retire_valid,
  input  logic           retire_taken,
  input  fetch_pkg::ip_t retire_ip,
  input  fetch_pkg::ip_t retire_target,
  output logic           btb_hit,
  output fetch_pkg::ip_t btb_target
);
  import fetch_pkg::*;

  localparam int unsigned ENTRIES = 2 ** `FETCH_BTB_IDX_W;
  localparam int unsigned TAG_LO  = FETCH_OFS_W + `FETCH_BTB_IDX_W;
  localparam int unsigned TAG_W   = `FETCH_IP_W - TAG_LO;

  logic [ENTRIES-1:0] valid;
  logic [TAG_W-1:0]   tag_mem    [ENTRIES];
  ip_t                target_mem [ENTRIES];

  btb_index_t       rd_idx;
  btb_index_t       wr_idx;
  logic [TAG_W-1:0] rd_tag;
  logic             wr_en;

  // index sits just above the block offset, tag is the rest
  assign rd_idx = fetch_ip[TAG_LO-1:FETCH_OFS_W];
  assign rd_tag = fetch_ip[`FETCH_IP_W-1:TAG_LO];
  assign wr_idx = retire_ip[TAG_LO-1:FETCH_OFS_W];

  assign wr_en = retire_valid && retire_taken; // only taken branches allocate

  // zero-cycle lookup
  assign btb_hit    = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign btb_target = target_mem[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // overwrite whatever held this slot
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx]    <= retire_ip[`FETCH_IP_W-1:TAG_LO];
      target_mem[wr_idx] <= retire_target;
    end
  end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  typedef logic [`FETCH_IP_W-1:0]      ip_t;
  typedef logic [`FETCH_GHR_W-1:0]     ghr_t;
  typedef logic [`FETCH_PHT_IDX_W-1:0] pht_index_t;
  typedef logic [`FETCH_BTB_IDX_W-1:0] btb_index_t;

  // byte offset bits inside one fetch block
  localparam int unsigned FETCH_OFS_W = $clog2(`FETCH_BLOCK_BYTES);

  // msb set means taken
  typedef enum logic [1:0] {
    CNT_STRONG_NT = 2'b00,
    CNT_WEAK_NT   = 2'b01,
    CNT_WEAK_T    = 2'b10,
    CNT_STRONG_T  = 2'b11
  } counter_e;

  typedef enum logic [1:0] {
    NEXT_SEQ     = 2'b00, // block + 16
    NEXT_TAKEN   = 2'b01, // predicted target
    NEXT_RESTORE = 2'b10  // mispredict from retire
  } next_kind_e;

endpackage

`default_nettype wire

//--- fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// fetch address width
`define FETCH_IP_W 32

// bytes fetched per cycle, one aligned block
`define FETCH_BLOCK_BYTES 16

// global history length in branches
`define FETCH_GHR_W 14

// counter tables hold 2**FETCH_PHT_IDX_W entries each
`define FETCH_PHT_IDX_W 10

// direct-mapped target buffer, 2**FETCH_BTB_IDX_W entries
`define FETCH_BTB_IDX_W 6

// history bits folded into the short and medium tables
`define FETCH_HIST_SHORT 2
`define FETCH_HIST_MID 6

// first fetch address after reset
`define FETCH_RESET_IP 32'h0000_1000

`endif
